// File: verilog/periph_pkg.sv
/*
  Shared types and constants of the peripheral slice.
  Register index comes from address bits 5..2, so bits 7..6 are ignored
  and the registers of a peripheral alias every 64 bytes.
  Peripheral number sits in address bits 11..8; only GPIO and timer exist.
*/
package periph_pkg;

    // Bus widths
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  reg_idx_t;

    // Peripheral select field
    localparam int unsigned PERIPH_SEL_LSB = 8;
    localparam int unsigned PERIPH_SEL_W   = 4;

    localparam logic [PERIPH_SEL_W-1:0] SEL_GPIO  = 4'd0;
    localparam logic [PERIPH_SEL_W-1:0] SEL_TIMER = 4'd1;

    // GPIO register map
    localparam reg_idx_t GPIO_DIR     = 4'd0;
    localparam reg_idx_t GPIO_OUT     = 4'd1;
    localparam reg_idx_t GPIO_IN      = 4'd2;
    localparam reg_idx_t GPIO_RISE_EN = 4'd3;

    // Timer register map, CTRL bit 0 enable, bit 1 reference tick
    localparam reg_idx_t TIMER_CTRL  = 4'd0;
    localparam reg_idx_t TIMER_COUNT = 4'd1;
    localparam reg_idx_t TIMER_CMP   = 4'd2;

    // Fabric controller event positions
    localparam int unsigned FC_EVT_W    = 32;
    localparam int unsigned EVT_DMA_PE  = 8;
    localparam int unsigned EVT_DMA_IRQ = 9;
    localparam int unsigned EVT_TIMER   = 10;
    localparam int unsigned EVT_PF      = 12;
    localparam int unsigned EVT_REF     = 14;
    localparam int unsigned EVT_GPIO    = 15;

    typedef struct packed {
        addr_t paddr;
        data_t pwdata;
        logic  pwrite;
        logic  psel;
        logic  penable;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        reg_idx_t idx;
        data_t    wdata;
        logic     we;
        logic     re;
    } reg_req_t;

    typedef enum logic {
        TMR_IDLE,
        TMR_RUN
    } timer_state_e;

endpackage

// File: verilog/apb_periph_decode.sv
/*
  APB slave decode, zero wait states, pready is tied high.
  Requests carry we/re only in the access phase of the selected peripheral.
  Unmapped peripheral numbers give pslverr and read zero.
*/
`timescale 1ns/100ps

module apb_periph_decode (
    input  periph_pkg::apb_req_t apb_req_i,
    output periph_pkg::apb_rsp_t apb_rsp_o,
    output periph_pkg::reg_req_t gpio_req_o,
    output periph_pkg::reg_req_t timer_req_o,
    input  periph_pkg::data_t    gpio_rdata_i,
    input  periph_pkg::data_t    timer_rdata_i
);

    import periph_pkg::*;

    logic [PERIPH_SEL_W-1:0] periph_sel;
    logic                    access;
    logic                    hit_gpio;
    logic                    hit_timer;
    reg_req_t                base_req;

    assign periph_sel = apb_req_i.paddr[PERIPH_SEL_LSB +: PERIPH_SEL_W];

    // Access phase of a transfer
    assign access    = apb_req_i.psel & apb_req_i.penable;
    assign hit_gpio  = (periph_sel == SEL_GPIO);
    assign hit_timer = (periph_sel == SEL_TIMER);

    //////////////////////////////////////////////////
    // Register requests
    //////////////////////////////////////////////////
    always_comb begin
        base_req.idx   = apb_req_i.paddr[5:2];
        base_req.wdata = apb_req_i.pwdata;
        base_req.we    = access & apb_req_i.pwrite;
        base_req.re    = access & ~apb_req_i.pwrite;

        gpio_req_o     = base_req;
        gpio_req_o.we  = base_req.we & hit_gpio;
        gpio_req_o.re  = base_req.re & hit_gpio;

        timer_req_o    = base_req;
        timer_req_o.we = base_req.we & hit_timer;
        timer_req_o.re = base_req.re & hit_timer;
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////
    always_comb begin
        case (periph_sel)
            SEL_GPIO:  apb_rsp_o.prdata = gpio_rdata_i;
            SEL_TIMER: apb_rsp_o.prdata = timer_rdata_i;
            default:   apb_rsp_o.prdata = '0;
        endcase
        apb_rsp_o.pready  = 1'b1;
        // Error only in the access phase of an unmapped transfer
        apb_rsp_o.pslverr = access & ~(hit_gpio | hit_timer);
    end

endmodule

// File: verilog/gpio_regs.sv
/*
  GPIO register block with DIR, OUT, RISE_EN and a synchronized input view.
  Inputs pass a 2-flop synchronizer; GPIO_IN lags the pins by 2 to 3 clocks.
  Event is a registered one-cycle pulse on any enabled rising input.
  NGPIO must be in 1..32; unused upper read bits are zero.
*/
`timescale 1ns/100ps

module gpio_regs #(
    parameter int unsigned NGPIO = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::reg_req_t req_i,
    output periph_pkg::data_t    rdata_o,
    input  logic [NGPIO-1:0]     gpio_in_i,
    output logic [NGPIO-1:0]     gpio_out_o,
    output logic [NGPIO-1:0]     gpio_dir_o,
    output logic                 gpio_event_o
);

    import periph_pkg::*;

    logic [NGPIO-1:0] dir_q;
    logic [NGPIO-1:0] out_q;
    logic [NGPIO-1:0] rise_en_q;
    logic [NGPIO-1:0] in_meta_q;
    logic [NGPIO-1:0] in_sync_q;
    logic [NGPIO-1:0] in_prev_q;
    logic [NGPIO-1:0] rise;
    logic             event_q;

    //////////////////////////////////////////////////
    // Software registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q     <= '0;
            out_q     <= '0;
            rise_en_q <= '0;
        end else if (req_i.we) begin
            case (req_i.idx)
                GPIO_DIR:     dir_q     <= req_i.wdata[NGPIO-1:0];
                GPIO_OUT:     out_q     <= req_i.wdata[NGPIO-1:0];
                GPIO_RISE_EN: rise_en_q <= req_i.wdata[NGPIO-1:0];
                // GPIO_IN is read only
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Input synchronizer and edge detect
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
            in_prev_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
            in_prev_q <= in_sync_q;
        end
    end

    assign rise = in_sync_q & ~in_prev_q & rise_en_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            event_q <= 1'b0;
        end else begin
            event_q <= |rise;
        end
    end

    // Read mux, zero outside a read access
    always_comb begin
        rdata_o = '0;
        if (req_i.re) begin
            case (req_i.idx)
                GPIO_DIR:     rdata_o[NGPIO-1:0] = dir_q;
                GPIO_OUT:     rdata_o[NGPIO-1:0] = out_q;
                GPIO_IN:      rdata_o[NGPIO-1:0] = in_sync_q;
                GPIO_RISE_EN: rdata_o[NGPIO-1:0] = rise_en_q;
                default: ;
            endcase
        end
    end

    assign gpio_out_o   = out_q;
    assign gpio_dir_o   = dir_q;
    assign gpio_event_o = event_q;

endmodule

// File: verilog/timer_unit.sv
/*
  Compare-and-wrap timer, 32-bit low half only.
  Ticks are system clocks or reference rise pulses, chosen by CTRL bit 1.
  Event is combinational during the tick that wraps COUNT from CMP to 0,
  so with clock ticks it repeats every CMP+1 cycles.
*/
`timescale 1ns/100ps

module timer_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::reg_req_t req_i,
    output periph_pkg::data_t    rdata_o,
    input  logic                 ref_tick_i,
    output logic                 timer_event_o
);

    import periph_pkg::*;

    timer_state_e state_q;
    timer_state_e state_d;
    logic         enable_q;
    logic         ref_sel_q;
    data_t        count_q;
    data_t        cmp_q;
    logic         tick;
    logic         wrap;

    //////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q  <= 1'b0;
            ref_sel_q <= 1'b0;
            cmp_q     <= '0;
        end else if (req_i.we) begin
            case (req_i.idx)
                TIMER_CTRL: begin
                    enable_q  <= req_i.wdata[0];
                    ref_sel_q <= req_i.wdata[1];
                end
                TIMER_CMP: cmp_q <= req_i.wdata;
                default: ;
            endcase
        end
    end

    // FSM follows the enable bit
    always_comb begin
        state_d = state_q;
        case (state_q)
            TMR_IDLE: if (enable_q) state_d = TMR_RUN;
            TMR_RUN:  if (!enable_q) state_d = TMR_IDLE;
            default:  state_d = TMR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TMR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////
    // Counter
    //////////////////////////////////////////////////
    assign tick = ref_sel_q ? ref_tick_i : 1'b1;
    assign wrap = (state_q == TMR_RUN) && tick && (count_q == cmp_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (req_i.we && (req_i.idx == TIMER_COUNT)) begin
            // Software load wins over counting
            count_q <= req_i.wdata;
        end else if (wrap) begin
            count_q <= '0;
        end else if ((state_q == TMR_RUN) && tick) begin
            count_q <= count_q + 32'd1;
        end
    end

    always_comb begin
        rdata_o = '0;
        if (req_i.re) begin
            case (req_i.idx)
                TIMER_CTRL:  rdata_o[1:0] = {ref_sel_q, enable_q};
                TIMER_COUNT: rdata_o      = count_q;
                TIMER_CMP:   rdata_o      = cmp_q;
                default: ;
            endcase
        end
    end

    assign timer_event_o = wrap;

endmodule

// File: verilog/ref_clk_edge.sv
/*
  Reference clock edge detector in the system clock domain.
  Reference clock must be much slower than clk_i, at least 3 clocks per level.
  Pulses are registered and last exactly one clk_i cycle.
*/
`timescale 1ns/100ps

module ref_clk_edge (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic slow_clk_i,
    output logic rise_o,
    output logic fall_o
);

    // Stage 0 may go metastable, stages 1 and 2 are compared
    logic [2:0] sync_q;
    logic       rise_q;
    logic       fall_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[1:0], slow_clk_i};
            rise_q <= sync_q[1] & ~sync_q[2];
            fall_q <= ~sync_q[1] & sync_q[2];
        end
    end

    assign rise_o = rise_q;
    assign fall_o = fall_q;

endmodule

// File: verilog/soc_periph.sv
/*
  Peripheral slice top: APB decode, GPIO, timer and reference edge detect.
  APB is zero wait state; all events are one-cycle pulses.
  Event vector bits not listed in the package are tied to zero.
*/
`timescale 1ns/100ps

module soc_periph #(
    parameter int unsigned NGPIO = 32
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          slow_clk_i,
    input  periph_pkg::apb_req_t          apb_req_i,
    output periph_pkg::apb_rsp_t          apb_rsp_o,
    input  logic [NGPIO-1:0]              gpio_in_i,
    output logic [NGPIO-1:0]              gpio_out_o,
    output logic [NGPIO-1:0]              gpio_dir_o,
    input  logic                          dma_pe_evt_i,
    input  logic                          dma_pe_irq_i,
    input  logic                          pf_evt_i,
    output logic [periph_pkg::FC_EVT_W-1:0] fc_events_o
);

    import periph_pkg::*;

    reg_req_t s_gpio_req;
    reg_req_t s_timer_req;
    data_t    s_gpio_rdata;
    data_t    s_timer_rdata;
    logic     s_gpio_event;
    logic     s_timer_event;
    logic     s_ref_rise;
    logic     s_ref_fall;

    apb_periph_decode i_decode (
        .apb_req_i     ( apb_req_i     ),
        .apb_rsp_o     ( apb_rsp_o     ),
        .gpio_req_o    ( s_gpio_req    ),
        .timer_req_o   ( s_timer_req   ),
        .gpio_rdata_i  ( s_gpio_rdata  ),
        .timer_rdata_i ( s_timer_rdata )
    );

    gpio_regs #(
        .NGPIO ( NGPIO )
    ) i_gpio (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .req_i        ( s_gpio_req   ),
        .rdata_o      ( s_gpio_rdata ),
        .gpio_in_i    ( gpio_in_i    ),
        .gpio_out_o   ( gpio_out_o   ),
        .gpio_dir_o   ( gpio_dir_o   ),
        .gpio_event_o ( s_gpio_event )
    );

    timer_unit i_timer (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .req_i         ( s_timer_req   ),
        .rdata_o       ( s_timer_rdata ),
        .ref_tick_i    ( s_ref_rise    ),
        .timer_event_o ( s_timer_event )
    );

    ref_clk_edge i_ref_edge (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .slow_clk_i ( slow_clk_i ),
        .rise_o     ( s_ref_rise ),
        .fall_o     ( s_ref_fall )
    );

    //////////////////////////////////////////////////
    // Fabric controller event vector
    //////////////////////////////////////////////////
    always_comb begin
        fc_events_o              = '0;
        fc_events_o[EVT_DMA_PE]  = dma_pe_evt_i;
        fc_events_o[EVT_DMA_IRQ] = dma_pe_irq_i;
        fc_events_o[EVT_TIMER]   = s_timer_event;
        fc_events_o[EVT_PF]      = pf_evt_i;
        // Both reference edges share one event line
        fc_events_o[EVT_REF]     = s_ref_rise | s_ref_fall;
        fc_events_o[EVT_GPIO]    = s_gpio_event;
    end

endmodule

// File: test/tb_apb_tasks.svh
/*
  APB master tasks for the peripheral testbench, driven on falling edges.
  A transfer is setup, access, then one idle cycle; results are sampled
  1 ns into the access phase. Uses clk, apb_req and apb_rsp of the includer.
*/
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

task automatic apb_transfer(input addr_t addr, input data_t wdata, input logic write,
                            output data_t rdata, output logic err);
    @(negedge clk);
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.pwrite  = write;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
endtask

task automatic apb_write(input addr_t addr, input data_t wdata, output logic err);
    data_t unused;
    apb_transfer(addr, wdata, 1'b1, unused, err);
endtask

task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
    apb_transfer(addr, '0, 1'b0, rdata, err);
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

`endif

// File: test/tb_soc_periph.sv
/*
  Testbench of the peripheral slice with NGPIO = 32.
  Inputs change on falling edges; event bits are sampled 1 ns after.
  Stops at the first failed check; a cycle counter bounds the run.
*/
`timescale 1ns/100ps

module tb_soc_periph;

    import periph_pkg::*;

    localparam int    TIMEOUT_CYCLES = 2000;
    localparam addr_t GPIO_BASE      = 32'h000;
    localparam addr_t TIMER_BASE     = 32'h100;
    localparam addr_t BAD_BASE       = 32'h300;
    localparam logic [31:0] EVT_USED = (32'd1 << EVT_DMA_PE) | (32'd1 << EVT_DMA_IRQ) |
                                       (32'd1 << EVT_TIMER) | (32'd1 << EVT_PF) |
                                       (32'd1 << EVT_REF) | (32'd1 << EVT_GPIO);

    logic        clk;
    logic        rst_n;
    logic        slow_clk;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic [31:0] gpio_dir;
    logic        dma_pe_evt;
    logic        dma_pe_irq;
    logic        pf_evt;
    logic [31:0] fc_events;
    int          cycle_count = 0;
    integer      seed = 32'h518fb377;

    soc_periph #(
        .NGPIO ( 32 )
    ) uut (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .slow_clk_i   ( slow_clk   ),
        .apb_req_i    ( apb_req    ),
        .apb_rsp_o    ( apb_rsp    ),
        .gpio_in_i    ( gpio_in    ),
        .gpio_out_o   ( gpio_out   ),
        .gpio_dir_o   ( gpio_dir   ),
        .dma_pe_evt_i ( dma_pe_evt ),
        .dma_pe_irq_i ( dma_pe_irq ),
        .pf_evt_i     ( pf_evt     ),
        .fc_events_o  ( fc_events  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_stop();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first failed check");
    endtask

    `include "tb_apb_tasks.svh"

    function automatic addr_t reg_addr(input addr_t base, input reg_idx_t idx);
        return base + (addr_t'(idx) << 2);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_stop();
        end
    endtask

    // Write, read back and compare one register
    task automatic reg_roundtrip(input addr_t addr, input string name, input data_t val);
        data_t rval;
        logic  err;
        apb_write(addr, val, err);
        check_eq({name, " write pslverr"}, err, 0);
        apb_read(addr, rval, err);
        check_eq({name, " read pslverr"}, err, 0);
        check_eq(name, rval, val);
    endtask

    // Number of cycles with the event bit high over a window
    task automatic count_events(input int idx, input int cycles, output int n);
        n = 0;
        repeat (cycles) begin
            @(negedge clk);
            #1;
            if (fc_events[idx]) n++;
        end
    endtask

    // Cycles until the event bit is next seen high
    // Gives limit + 1 when the event never comes
    task automatic cycles_to_event(input int idx, input int limit, output int n);
        n = 0;
        do begin
            @(negedge clk);
            #1;
            n++;
        end while (!fc_events[idx] && n <= limit);
    endtask

    task automatic set_slow_clk(input logic value);
        @(negedge clk);
        slow_clk = value;
    endtask

    //////////////////////////////////////////////////
    // Concurrent checks and timeout
    //////////////////////////////////////////////////
    pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else begin
        $display("ERROR at %0t: pready got 0 expected 1", $time);
        fail_stop();
    end

    unused_events_zero: assert property (@(posedge clk) (fc_events & ~EVT_USED) == '0)
    else begin
        $display("ERROR at %0t: fc_events_o got %h expected %h", $time,
                 $sampled(fc_events), $sampled(fc_events) & EVT_USED);
        fail_stop();
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
            fail_stop();
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        data_t dir_val;
        data_t out_val;
        data_t in_val;
        data_t rval;
        logic  err;
        int    n;
        int    b;
        int    c;
        int    cmp_n;

        rst_n      = 1'b0;
        slow_clk   = 1'b0;
        apb_req    = '0;
        gpio_in    = '0;
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        pf_evt     = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_eq("gpio_out_o", gpio_out, 0);
        check_eq("gpio_dir_o", gpio_dir, 0);
        check_eq("fc_events_o", fc_events, 0);

        // Register access
        dir_val = $random(seed);
        out_val = $random(seed);
        reg_roundtrip(reg_addr(GPIO_BASE, GPIO_DIR), "GPIO_DIR", dir_val);
        check_eq("gpio_dir_o", gpio_dir, dir_val);
        reg_roundtrip(reg_addr(GPIO_BASE, GPIO_OUT), "GPIO_OUT", out_val);
        check_eq("gpio_out_o", gpio_out, out_val);
        reg_roundtrip(reg_addr(TIMER_BASE, TIMER_CMP), "TIMER_CMP", $random(seed));

        // Unmapped peripheral
        // Index 0 would alias GPIO_DIR
        apb_read(BAD_BASE, rval, err);
        check_eq("unmapped read pslverr", err, 1);
        check_eq("unmapped prdata", rval, 0);
        apb_write(BAD_BASE, $random(seed), err);
        check_eq("unmapped write pslverr", err, 1);
        apb_read(reg_addr(GPIO_BASE, GPIO_DIR), rval, err);
        check_eq("GPIO_DIR after unmapped write", rval, dir_val);
        apb_read(reg_addr(GPIO_BASE, GPIO_OUT), rval, err);
        check_eq("GPIO_OUT after unmapped write", rval, out_val);

        // GPIO input view and rise event
        in_val = $random(seed);
        @(negedge clk);
        gpio_in = in_val;
        wait_cycles(4);
        apb_read(reg_addr(GPIO_BASE, GPIO_IN), rval, err);
        check_eq("GPIO_IN", rval, in_val);
        b = $unsigned($random(seed)) % 32;
        c = (b + 7) % 32;
        @(negedge clk);
        gpio_in = '0;
        wait_cycles(4);
        apb_write(reg_addr(GPIO_BASE, GPIO_RISE_EN), 32'd1 << b, err);
        @(negedge clk);
        gpio_in = 32'd1 << b;
        count_events(EVT_GPIO, 4, n);
        check_eq("gpio event count on enabled rise", n, 1);
        count_events(EVT_GPIO, 8, n);
        check_eq("gpio event count after enabled rise", n, 0);
        @(negedge clk);
        gpio_in = (32'd1 << b) | (32'd1 << c);
        count_events(EVT_GPIO, 8, n);
        check_eq("gpio event count on disabled rise", n, 0);

        // Timer on clock ticks
        cmp_n = 3 + ($unsigned($random(seed)) % 18);
        apb_write(reg_addr(TIMER_BASE, TIMER_CMP), cmp_n, err);
        apb_write(reg_addr(TIMER_BASE, TIMER_COUNT), 0, err);
        apb_write(reg_addr(TIMER_BASE, TIMER_CTRL), 32'h1, err);
        cycles_to_event(EVT_TIMER, 64, n);
        assert (n <= 64) else begin
            $display("Timer event never fired with clock ticks and CMP = %0d", cmp_n);
            fail_stop();
        end
        repeat (3) begin
            cycles_to_event(EVT_TIMER, 64, n);
            check_eq("timer event interval", n, cmp_n + 1);
        end
        apb_write(reg_addr(TIMER_BASE, TIMER_CTRL), 32'h0, err);

        // Reference edges
        // Each level lasts nine clocks
        repeat (4) begin
            set_slow_clk(~slow_clk);
            count_events(EVT_REF, 4, n);
            check_eq("ref event count after edge", n, 1);
            count_events(EVT_REF, 4, n);
            check_eq("ref event count while stable", n, 0);
        end

        // Timer on reference ticks
        // CMP = 2 wraps on every third rise
        apb_write(reg_addr(TIMER_BASE, TIMER_CMP), 2, err);
        apb_write(reg_addr(TIMER_BASE, TIMER_COUNT), 0, err);
        apb_write(reg_addr(TIMER_BASE, TIMER_CTRL), 32'h3, err);
        for (int r = 1; r <= 6; r++) begin
            set_slow_clk(1'b1);
            count_events(EVT_TIMER, 8, n);
            check_eq("timer event count on ref rise", n, (r % 3 == 0) ? 1 : 0);
            set_slow_clk(1'b0);
            count_events(EVT_TIMER, 8, n);
            check_eq("timer event count on ref fall", n, 0);
        end
        apb_write(reg_addr(TIMER_BASE, TIMER_CTRL), 32'h0, err);

        // Pass-through events over all eight input patterns
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            {pf_evt, dma_pe_irq, dma_pe_evt} = k[2:0];
            #1;
            check_eq("fc_events_o[12,9,8]", {fc_events[EVT_PF], fc_events[EVT_DMA_IRQ],
                     fc_events[EVT_DMA_PE]}, k);
        end
        @(negedge clk);
        {pf_evt, dma_pe_irq, dma_pe_evt} = 3'b000;
        wait_cycles(4);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: flist.f
+incdir+test
verilog/periph_pkg.sv
verilog/apb_periph_decode.sv
verilog/gpio_regs.sv
verilog/timer_unit.sv
verilog/ref_clk_edge.sv
verilog/soc_periph.sv
test/tb_soc_periph.sv
